// ==== Makefile ====
BIN := obj_dir/Vmmu_tb

all: run

$(BIN): mmu.f $(wildcard src/*.sv bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f mmu.f \
		--top-module mmu_tb -Mdir obj_dir -o Vmmu_tb

run: $(BIN)
	./$(BIN) > sim.log 2>&1; rc=$$?; cat sim.log; \
	if [ $$rc -ne 0 ] || grep -q "sim failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== bench/mmu_chk.sv ====
`timescale 1ns/10ps

module mmu_chk import mmu_pkg::*; (
    input logic             clk,
    input logic             rst,
    input logic             req_i,
    input logic             rvalid_i,
    input logic             err_i,
    input logic [MEM_W-1:0] rdata_i,
    input dec_state_e       state_i
);

    a_one_kind: assert property (@(posedge clk) disable iff (!rst) !(rvalid_i && err_i))
        else $error("read valid and error asserted together");

    // Only one request in flight
    a_req_idle: assert property (@(posedge clk) disable iff (!rst) req_i |-> state_i == ST_IDLE)
        else $error("request arrived while decoder busy");

    a_sram_seq: assert property (@(posedge clk) disable iff (!rst)
        state_i == ST_SRAM_RD |=> state_i == ST_SRAM_DONE)
        else $error("SRAM read state not followed by done state");

    a_rdata_zero: assert property (@(posedge clk) disable iff (!rst) !rvalid_i |-> rdata_i == '0)
        else $error("read data nonzero without read valid");

endmodule : mmu_chk

bind mem_decoder mmu_chk mmu_chk_i (
    .clk(clk),
    .rst(rst),
    .req_i(mem_req_i),
    .rvalid_i(mem_rvalid_o),
    .err_i(mem_err_o),
    .rdata_i(mem_rdata_o),
    .state_i(state_q)
);

// ==== bench/mmu_tb.sv ====
`timescale 1ns/10ps

module mmu_tb import mmu_pkg::*; ();

    logic                 clk;
    logic                 rst;
    logic                 mem_req;
    logic [ADDR_W-1:0]    mem_addr;
    logic                 mem_we;
    logic [BE_W-1:0]      mem_be;
    logic [MEM_W-1:0]     mem_wdata;
    logic [GPIO_PINS-1:0] gpio_in;
    logic                 mem_rvalid;
    logic                 mem_err;
    logic [MEM_W-1:0]     mem_rdata;
    logic [GPIO_PINS-1:0] gpio_out;
    logic [GPIO_PINS-1:0] gpio_oe;

    // Reference model state
    logic [GPIO_PINS-1:0] dir_m;
    logic [GPIO_PINS-1:0] val_m;
    logic [MEM_W-1:0]     sram_m [SRAM_WORDS];
    bit   [MEM_W-1:0]     mask_m [SRAM_WORDS];
    bit                   loaded;
    int                   load_edge;
    int                   load_val;
    int                   edges = 0;

    mmu mmu_i (
        .clk(clk),
        .rst(rst),
        .mem_req_i(mem_req),
        .mem_addr_i(mem_addr),
        .mem_we_i(mem_we),
        .mem_be_i(mem_be),
        .mem_wdata_i(mem_wdata),
        .gpio_in_i(gpio_in),
        .mem_rvalid_o(mem_rvalid),
        .mem_err_o(mem_err),
        .mem_rdata_o(mem_rdata),
        .gpio_out_o(gpio_out),
        .gpio_oe_o(gpio_oe)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Rising edge count, read only at falling edges
    always @(posedge clk) begin
        edges <= edges + 1;
    end

    task automatic check(input logic [MEM_W-1:0] actual, input logic [MEM_W-1:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, msg, actual, expected);
            $display("sim failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic idle(input int unsigned cycles);
        repeat (cycles) @(posedge clk);
    endtask

    function automatic mem_region_e region_of(input logic [ADDR_W-1:0] addr);
        if (addr >= STORAGE_BASE) return REGION_STORAGE;
        if (addr >= SRAM_BASE) return REGION_SRAM;
        if (addr == TIMER_ADDR) return REGION_TIMER;
        if (addr >= GPIO_DIR_BASE && addr < TIMER_ADDR) return REGION_GPIO;
        return REGION_RESERVED;
    endfunction

    function automatic logic [ADDR_W-1:0] pick_addr();
        int unsigned r;
        r = $urandom_range(0, 99);
        if (r < 30) return GPIO_DIR_BASE + ADDR_W'($urandom_range(0, 2*GPIO_PINS-1));
        if (r < 40) return TIMER_ADDR;
        // Most SRAM traffic hits 16 words so data gets read back
        if (r < 77) return SRAM_BASE + ADDR_W'($urandom_range(0, 15));
        if (r < 85) return SRAM_BASE + ADDR_W'($urandom_range(0, SRAM_WORDS-1));
        if (r < 90) return ADDR_W'($urandom_range(0, 'h100));
        if (r < 94) return ADDR_W'($urandom_range('h116, 'hFFF));
        return STORAGE_BASE + ADDR_W'($urandom_range(0, 'hFFFF_DFFF));
    endfunction

    // One request, its response and the model update
    task automatic access(input logic [ADDR_W-1:0] addr, input logic we,
                          input logic [BE_W-1:0] be, input logic [MEM_W-1:0] wdata);
        logic [GPIO_PINS-1:0] pins;
        logic [GPIO_PINS-1:0] exp_oe;
        logic [MEM_W-1:0]     exp_data;
        logic [MEM_W-1:0]     mask;
        logic                 exp_err;
        int                   exp_lat;
        int                   lat;
        int                   idx;
        int                   cyc0;
        int                   b;
        pins = GPIO_PINS'($urandom);
        @(posedge clk);
        mem_req   <= 1'b1;
        mem_addr  <= addr;
        mem_we    <= we;
        mem_be    <= be;
        mem_wdata <= wdata;
        gpio_in   <= pins;
        @(posedge clk);
        mem_req   <= 1'b0;
        @(negedge clk);
        cyc0 = edges;
        lat  = 0;
        while (!mem_rvalid && !mem_err) begin
            if (lat == 20) begin
                $display("Timeout: no response to address %h within 20 cycles, at %0t ns",
                         addr, $time);
                $display("sim failed");
                $fatal(1, "response timeout");
            end
            lat++;
            @(negedge clk);
        end
        exp_err  = 1'b0;
        exp_data = '0;
        mask     = '1;
        exp_lat  = 1;
        case (region_of(addr))
            REGION_GPIO: begin
                if (addr < GPIO_VAL_BASE) begin
                    idx = int'(addr - GPIO_DIR_BASE);
                    if (we) dir_m[idx] = wdata[0];
                    else exp_data[0] = dir_m[idx];
                end else begin
                    idx = int'(addr - GPIO_VAL_BASE);
                    // Writes need an output pin, reads an input pin
                    if (dir_m[idx] == we) exp_err = 1'b1;
                    else if (we) val_m[idx] = wdata[0];
                    else exp_data[0] = pins[idx];
                end
            end
            REGION_TIMER: begin
                if (we) begin
                    loaded    = 1'b1;
                    load_edge = cyc0 + 1;
                    load_val  = int'(wdata);
                end else begin
                    exp_data[0] = !loaded || (cyc0 - load_edge >= load_val);
                end
            end
            REGION_SRAM: begin
                exp_lat = 2;
                idx     = int'(addr - SRAM_BASE);
                if (we) begin
                    for (b = 0; b < BE_W; b++) begin
                        if (be[b]) begin
                            sram_m[idx][8*b +: 8] = wdata[8*b +: 8];
                            mask_m[idx][8*b +: 8] = 8'hFF;
                        end
                    end
                end else begin
                    // Only bytes written earlier
                    exp_data = sram_m[idx] & mask_m[idx];
                    mask     = mask_m[idx];
                end
            end
            default: exp_err = 1'b1;
        endcase
        exp_oe = ~dir_m;
        check(MEM_W'(lat), MEM_W'(exp_lat), "response latency");
        check(MEM_W'(mem_err), MEM_W'(exp_err), "error flag");
        check(MEM_W'(mem_rvalid), MEM_W'(!exp_err), "read valid flag");
        check(mem_rdata & mask, exp_data, "read data");
        check(MEM_W'(gpio_oe), MEM_W'(exp_oe), "gpio output enables");
        check(MEM_W'(gpio_out), MEM_W'(val_m), "gpio output values");
        @(negedge clk);
        check(MEM_W'({mem_rvalid, mem_err}), '0, "single response cycle");
        check(mem_rdata, '0, "read data outside response");
    endtask

    initial begin
        logic [ADDR_W-1:0] addr;
        logic              we;
        void'($urandom(18718));
        rst       = 1'b0;
        mem_req   = 1'b0;
        mem_addr  = '0;
        mem_we    = 1'b0;
        mem_be    = '0;
        mem_wdata = '0;
        gpio_in   = '0;
        dir_m     = '1;
        val_m     = '0;
        loaded    = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;

        // Timer after reset, then a load of 8 read at once and after 12 idle cycles
        access(TIMER_ADDR, 1'b0, '1, '0);
        access(TIMER_ADDR, 1'b1, '1, 32'd8);
        access(TIMER_ADDR, 1'b0, '1, '0);
        idle(12);
        access(TIMER_ADDR, 1'b0, '1, '0);

        repeat (400) begin
            addr = pick_addr();
            we   = 1'($urandom_range(0, 1));
            access(addr, we, BE_W'($urandom_range(1, 15)),
                   addr == TIMER_ADDR ? MEM_W'($urandom_range(0, 40)) : $urandom);
            idle($urandom_range(0, 6));
        end
        $display("sim passed");
        $finish;
    end

endmodule : mmu_tb

// ==== mmu.f ====
src/mmu_pkg.sv
src/mem_decoder.sv
src/gpio_bank.sv
src/digital_timer.sv
src/scratch_sram.sv
src/mmu.sv
bench/mmu_chk.sv
bench/mmu_tb.sv

// ==== src/digital_timer.sv ====
`timescale 1ns/10ps

module digital_timer import mmu_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             timer_load_i,
    input  logic [MEM_W-1:0] timer_val_i,
    output logic             timer_expired_o
);

    logic [MEM_W-1:0] count_q;

    // Load wins over the count, counting stops at zero
    always_ff @(posedge clk) begin
        if (!rst) begin
            count_q <= '0;
        end else if (timer_load_i) begin
            count_q <= timer_val_i;
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign timer_expired_o = count_q == '0;

endmodule : digital_timer

// ==== src/gpio_bank.sv ====
`timescale 1ns/10ps

module gpio_bank import mmu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  gpio_sel_i,
    input  logic                  gpio_we_i,
    input  logic [GPIO_IDX_W-1:0] gpio_idx_i,
    input  logic                  gpio_is_dir_i,
    input  logic                  gpio_bit_i,
    input  logic [GPIO_PINS-1:0]  gpio_in_i,
    output logic                  gpio_rbit_o,
    output logic                  gpio_fault_o,
    output logic [GPIO_PINS-1:0]  gpio_out_o,
    output logic [GPIO_PINS-1:0]  gpio_oe_o
);

    // Direction 1 is input, 0 is output
    logic [GPIO_PINS-1:0] dir_q;
    logic [GPIO_PINS-1:0] val_q;
    logic                 pin_is_in;

    assign pin_is_in = dir_q[gpio_idx_i];

    // Value writes need an output pin, value reads need an input pin
    assign gpio_fault_o = gpio_sel_i && !gpio_is_dir_i && (gpio_we_i ? pin_is_in : !pin_is_in);

    assign gpio_rbit_o = gpio_is_dir_i ? pin_is_in : gpio_in_i[gpio_idx_i];

    always_ff @(posedge clk) begin
        if (!rst) begin
            dir_q <= '1;
            val_q <= '0;
        end else if (gpio_sel_i && gpio_we_i) begin
            if (gpio_is_dir_i) begin
                dir_q[gpio_idx_i] <= gpio_bit_i;
            end else if (!pin_is_in) begin
                val_q[gpio_idx_i] <= gpio_bit_i;
            end
        end
    end

    // Pins only drive when set as outputs
    assign gpio_oe_o  = ~dir_q;
    assign gpio_out_o = val_q;

endmodule : gpio_bank

// ==== src/mem_decoder.sv ====
`timescale 1ns/10ps

module mem_decoder import mmu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_req_i,
    input  logic [ADDR_W-1:0]     mem_addr_i,
    input  logic                  mem_we_i,
    input  logic [BE_W-1:0]       mem_be_i,
    input  logic [MEM_W-1:0]      mem_wdata_i,
    input  logic                  gpio_rbit_i,
    input  logic                  gpio_fault_i,
    input  logic                  timer_expired_i,
    input  logic [MEM_W-1:0]      sram_rdata_i,
    output logic                  mem_rvalid_o,
    output logic                  mem_err_o,
    output logic [MEM_W-1:0]      mem_rdata_o,
    output logic                  gpio_sel_o,
    output logic                  gpio_we_o,
    output logic [GPIO_IDX_W-1:0] gpio_idx_o,
    output logic                  gpio_is_dir_o,
    output logic                  gpio_bit_o,
    output logic                  timer_load_o,
    output logic [MEM_W-1:0]      timer_val_o,
    output logic                  sram_en_o,
    output logic                  sram_we_o,
    output logic [SRAM_IDX_W-1:0] sram_idx_o,
    output logic [BE_W-1:0]       sram_be_o,
    output logic [MEM_W-1:0]      sram_wdata_o
);

    dec_state_e  state_q, state_d;
    mem_region_e region;

    // Captured request, only valid while a request is in flight
    logic                  we_q;
    logic [BE_W-1:0]       be_q;
    logic [MEM_W-1:0]      wdata_q;
    logic                  gpio_is_dir_q;
    logic [GPIO_IDX_W-1:0] gpio_idx_q;
    logic [SRAM_IDX_W-1:0] sram_idx_q;

    logic                  addr_is_dir;
    logic [ADDR_W-1:0]     gpio_off;
    logic [ADDR_W-1:0]     sram_off;

    // Region classification of the incoming address
    always_comb begin
        region = REGION_RESERVED;
        if (mem_addr_i >= GPIO_DIR_BASE && mem_addr_i < GPIO_VAL_BASE + ADDR_W'(GPIO_PINS)) begin
            region = REGION_GPIO;
        end else if (mem_addr_i == TIMER_ADDR) begin
            region = REGION_TIMER;
        end else if (mem_addr_i >= STORAGE_BASE) begin
            region = REGION_STORAGE;
        end else if (mem_addr_i >= SRAM_BASE) begin
            region = REGION_SRAM;
        end
    end

    // Device indices, offsets from each region base
    assign addr_is_dir = mem_addr_i < GPIO_VAL_BASE;
    assign gpio_off    = mem_addr_i - (addr_is_dir ? GPIO_DIR_BASE : GPIO_VAL_BASE);
    assign sram_off    = mem_addr_i - SRAM_BASE;

    always_comb begin
        state_d = ST_IDLE;
        case (state_q)
            ST_IDLE: begin
                if (mem_req_i) begin
                    case (region)
                        REGION_GPIO:  state_d = ST_GPIO;
                        REGION_TIMER: state_d = ST_TIMER;
                        REGION_SRAM:  state_d = ST_SRAM_RD;
                        default:      state_d = ST_ERROR;
                    endcase
                end
            end
            ST_SRAM_RD: state_d = ST_SRAM_DONE;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && mem_req_i) begin
            we_q          <= mem_we_i;
            be_q          <= mem_be_i;
            wdata_q       <= mem_wdata_i;
            gpio_is_dir_q <= addr_is_dir;
            gpio_idx_q    <= gpio_off[GPIO_IDX_W-1:0];
            sram_idx_q    <= sram_off[SRAM_IDX_W-1:0];
        end
    end

    // One response pulse per request; writes answer with zero data
    always_ff @(posedge clk) begin
        if (!rst) begin
            mem_rvalid_o <= 1'b0;
            mem_err_o    <= 1'b0;
            mem_rdata_o  <= '0;
        end else begin
            mem_rvalid_o <= 1'b0;
            mem_err_o    <= 1'b0;
            mem_rdata_o  <= '0;
            case (state_q)
                ST_GPIO: begin
                    if (gpio_fault_i) begin
                        mem_err_o <= 1'b1;
                    end else begin
                        mem_rvalid_o <= 1'b1;
                        mem_rdata_o  <= we_q ? '0 : {{(MEM_W-1){1'b0}}, gpio_rbit_i};
                    end
                end
                ST_TIMER: begin
                    mem_rvalid_o <= 1'b1;
                    mem_rdata_o  <= we_q ? '0 : {{(MEM_W-1){1'b0}}, timer_expired_i};
                end
                ST_SRAM_DONE: begin
                    mem_rvalid_o <= 1'b1;
                    mem_rdata_o  <= we_q ? '0 : sram_rdata_i;
                end
                ST_ERROR: mem_err_o <= 1'b1;
                default: ;
            endcase
        end
    end

    // Device side, driven from the captured fields
    assign gpio_sel_o    = state_q == ST_GPIO;
    assign gpio_we_o     = we_q;
    assign gpio_idx_o    = gpio_idx_q;
    assign gpio_is_dir_o = gpio_is_dir_q;
    assign gpio_bit_o    = wdata_q[0];

    assign timer_load_o  = state_q == ST_TIMER && we_q;
    assign timer_val_o   = wdata_q;

    assign sram_en_o     = state_q == ST_SRAM_RD;
    assign sram_we_o     = we_q;
    assign sram_idx_o    = sram_idx_q;
    assign sram_be_o     = be_q;
    assign sram_wdata_o  = wdata_q;

endmodule : mem_decoder

// ==== src/mmu.sv ====
`timescale 1ns/10ps

module mmu import mmu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mem_req_i,
    input  logic [ADDR_W-1:0]    mem_addr_i,
    input  logic                 mem_we_i,
    input  logic [BE_W-1:0]      mem_be_i,
    input  logic [MEM_W-1:0]     mem_wdata_i,
    input  logic [GPIO_PINS-1:0] gpio_in_i,
    output logic                 mem_rvalid_o,
    output logic                 mem_err_o,
    output logic [MEM_W-1:0]     mem_rdata_o,
    output logic [GPIO_PINS-1:0] gpio_out_o,
    output logic [GPIO_PINS-1:0] gpio_oe_o
);

    // GPIO link
    logic                  gpio_sel;
    logic                  gpio_we;
    logic [GPIO_IDX_W-1:0] gpio_idx;
    logic                  gpio_is_dir;
    logic                  gpio_bit;
    logic                  gpio_rbit;
    logic                  gpio_fault;

    // Timer link
    logic                  timer_load;
    logic [MEM_W-1:0]      timer_val;
    logic                  timer_expired;

    // SRAM link
    logic                  sram_en;
    logic                  sram_we;
    logic [SRAM_IDX_W-1:0] sram_idx;
    logic [BE_W-1:0]       sram_be;
    logic [MEM_W-1:0]      sram_wdata;
    logic [MEM_W-1:0]      sram_rdata;

    mem_decoder mem_decoder_i (
        .clk(clk),
        .rst(rst),
        .mem_req_i(mem_req_i),
        .mem_addr_i(mem_addr_i),
        .mem_we_i(mem_we_i),
        .mem_be_i(mem_be_i),
        .mem_wdata_i(mem_wdata_i),
        .gpio_rbit_i(gpio_rbit),
        .gpio_fault_i(gpio_fault),
        .timer_expired_i(timer_expired),
        .sram_rdata_i(sram_rdata),
        .mem_rvalid_o(mem_rvalid_o),
        .mem_err_o(mem_err_o),
        .mem_rdata_o(mem_rdata_o),
        .gpio_sel_o(gpio_sel),
        .gpio_we_o(gpio_we),
        .gpio_idx_o(gpio_idx),
        .gpio_is_dir_o(gpio_is_dir),
        .gpio_bit_o(gpio_bit),
        .timer_load_o(timer_load),
        .timer_val_o(timer_val),
        .sram_en_o(sram_en),
        .sram_we_o(sram_we),
        .sram_idx_o(sram_idx),
        .sram_be_o(sram_be),
        .sram_wdata_o(sram_wdata)
    );

    gpio_bank gpio_bank_i (
        .clk(clk),
        .rst(rst),
        .gpio_sel_i(gpio_sel),
        .gpio_we_i(gpio_we),
        .gpio_idx_i(gpio_idx),
        .gpio_is_dir_i(gpio_is_dir),
        .gpio_bit_i(gpio_bit),
        .gpio_in_i(gpio_in_i),
        .gpio_rbit_o(gpio_rbit),
        .gpio_fault_o(gpio_fault),
        .gpio_out_o(gpio_out_o),
        .gpio_oe_o(gpio_oe_o)
    );

    digital_timer digital_timer_i (
        .clk(clk),
        .rst(rst),
        .timer_load_i(timer_load),
        .timer_val_i(timer_val),
        .timer_expired_o(timer_expired)
    );

    scratch_sram scratch_sram_i (
        .clk(clk),
        .sram_en_i(sram_en),
        .sram_we_i(sram_we),
        .sram_idx_i(sram_idx),
        .sram_be_i(sram_be),
        .sram_wdata_i(sram_wdata),
        .sram_rdata_o(sram_rdata)
    );

endmodule : mmu

// ==== src/mmu_pkg.sv ====
package mmu_pkg;

    // Bus widths
    localparam int unsigned MEM_W  = 32;
    localparam int unsigned BE_W   = MEM_W / 8;
    localparam int unsigned ADDR_W = 32;

    // GPIO bank
    localparam int unsigned GPIO_PINS  = 10;
    localparam int unsigned GPIO_IDX_W = $clog2(GPIO_PINS);

    // Address map
    // Direction registers at 0x101..0x10A, pin values at 0x10B..0x114
    localparam logic [ADDR_W-1:0] GPIO_DIR_BASE = 32'h0000_0101;
    localparam logic [ADDR_W-1:0] GPIO_VAL_BASE = 32'h0000_010B;
    localparam logic [ADDR_W-1:0] TIMER_ADDR    = 32'h0000_0115;
    localparam logic [ADDR_W-1:0] SRAM_BASE     = 32'h0000_1000;
    localparam logic [ADDR_W-1:0] STORAGE_BASE  = 32'h0000_2000;

    // Scratch memory
    localparam int unsigned SRAM_WORDS = 4096;
    localparam int unsigned SRAM_IDX_W = $clog2(SRAM_WORDS);

    // Address regions
    typedef enum logic [2:0] {
        REGION_RESERVED,
        REGION_GPIO,
        REGION_TIMER,
        REGION_SRAM,
        REGION_STORAGE
    } mem_region_e;

    // Decoder FSM states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_GPIO,
        ST_TIMER,
        ST_SRAM_RD,
        ST_SRAM_DONE,
        ST_ERROR
    } dec_state_e;

endpackage : mmu_pkg

// ==== src/scratch_sram.sv ====
`timescale 1ns/10ps

module scratch_sram import mmu_pkg::*; (
    input  logic                  clk,
    input  logic                  sram_en_i,
    input  logic                  sram_we_i,
    input  logic [SRAM_IDX_W-1:0] sram_idx_i,
    input  logic [BE_W-1:0]       sram_be_i,
    input  logic [MEM_W-1:0]      sram_wdata_i,
    output logic [MEM_W-1:0]      sram_rdata_o
);

    logic [MEM_W-1:0] mem_q [SRAM_WORDS];

    // Byte lane writes
    always_ff @(posedge clk) begin
        if (sram_en_i && sram_we_i) begin
            for (int b = 0; b < BE_W; b++) begin
                if (sram_be_i[b]) begin
                    mem_q[sram_idx_i][8*b +: 8] <= sram_wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Read port returns the word as it was before any write in this cycle
    always_ff @(posedge clk) begin
        if (sram_en_i) begin
            sram_rdata_o <= mem_q[sram_idx_i];
        end
    end

endmodule : scratch_sram
